// ==== common/nand_bus_pkg.sv ====
package nand_bus_pkg;

    // ##################################################
    // deserializer geometry
    // ##################################################

    // samples per pin per clk_div cycle
    localparam int SERDES_RATIO = 8;

    // dq pins on the flash bus
    localparam int DQ_LANES = 8;

    localparam int DQ_SLICE_W = SERDES_RATIO * DQ_LANES;
    localparam int RD_WORD_W  = 2 * DQ_LANES;
    localparam int STROBE_W   = 2;

    // ##################################################
    // bus types
    // ##################################################

    // bit 0 is the earliest sample
    typedef logic [SERDES_RATIO-1:0]   dqs_slice_t;
    typedef logic [DQ_SLICE_W-1:0]     dq_slice_t;

    // previous slice in the low half, current slice in the high half
    typedef logic [2*SERDES_RATIO-1:0] dqs_pair_t;
    typedef logic [2*DQ_SLICE_W-1:0]   dq_pair_t;

    typedef logic [RD_WORD_W-1:0]      rd_word_t;
    typedef logic [STROBE_W-1:0]       rd_strobe_t;

endpackage

// ==== common/rd_align_pkg.sv ====
package rd_align_pkg;

    import nand_bus_pkg::*;

    // ##################################################
    // read preamble search
    // ##################################################

    // pattern in time order: 0 0 x x 1 1 1, oldest sample in bit 0
    localparam int PREAMBLE_SPAN = 7;
    localparam logic [PREAMBLE_SPAN-1:0] PREAMBLE_MASK  = 7'b111_0011;
    localparam logic [PREAMBLE_SPAN-1:0] PREAMBLE_VALUE = 7'b111_0000;

    // window start positions tried inside one dqs pair
    localparam int SEARCH_OFFSETS = 8;

    // ##################################################
    // fixed bit-slip and word selection
    // ##################################################

    localparam int DQS_SLIP = 6;
    localparam int DQ_SLIP  = DQS_SLIP * DQ_LANES;

    // sample bytes of the pair that form the word
    localparam int LO_SAMPLE = 7;
    localparam int HI_SAMPLE = 3;

    // bit positions of those bytes after the dq slip
    localparam int LO_BIT = LO_SAMPLE * DQ_LANES - DQ_SLIP;
    localparam int HI_BIT = (SERDES_RATIO + HI_SAMPLE) * DQ_LANES - DQ_SLIP;

    localparam rd_strobe_t STROBE_WORD = 2'b01;

    typedef enum logic [1:0] {
        ALIGN_IDLE,
        ALIGN_SEARCH,
        ALIGN_LOCKED
    } align_state_t;

endpackage

// ==== common/rd_capture_if.sv ====
`timescale 1ns/1ps

interface rd_capture_if
    import nand_bus_pkg::*, rd_align_pkg::*;
();

    // aligned dqs history from the lock finder
    dqs_pair_t    dqs_hist;
    logic         locked;
    align_state_t lock_state;

    // sample-ordered dq history from the buffer
    dq_pair_t     dq_hist;

    modport finder_mp (
        output dqs_hist,
        output locked,
        output lock_state
    );

    modport buffer_mp (
        output dq_hist
    );

    modport extract_mp (
        input dqs_hist,
        input locked,
        input lock_state,
        input dq_hist
    );

endinterface

// ==== hw/rd_capture/dqs_lock_finder.sv ====
`timescale 1ns/1ps

module dqs_lock_finder
    import nand_bus_pkg::*, rd_align_pkg::*;
(
    input  logic                  clk_div,
    input  logic                  usr_rst,
    input  dqs_slice_t            i_dqs_slice,
    input  logic                  i_rd_window,
    rd_capture_if.finder_mp       bus
);

    dqs_slice_t   prev_slice;
    dqs_pair_t    cur_pair;
    dqs_pair_t    dqs_hist_q;
    logic         win_prev;
    logic         window_valid;
    logic         preamble_hit;
    align_state_t state;
    align_state_t state_nxt;

    // ##################################################
    // window qualification
    // ##################################################

    // receive window must hold for two slices in a row
    always_ff @(posedge clk_div or posedge usr_rst) begin
        if (usr_rst) begin
            win_prev     <= 1'b0;
            window_valid <= 1'b0;
        end else begin
            win_prev     <= i_rd_window;
            window_valid <= win_prev & i_rd_window;
        end
    end

    // ##################################################
    // dqs history
    // ##################################################

    assign cur_pair = {i_dqs_slice, prev_slice};

    always_ff @(posedge clk_div or posedge usr_rst) begin
        if (usr_rst) begin
            prev_slice <= '0;
            dqs_hist_q <= '0;
        end else begin
            prev_slice <= i_dqs_slice;
            dqs_hist_q <= cur_pair;
        end
    end

    // ##################################################
    // preamble search and lock
    // ##################################################

    // masked compare at every offset of the incoming pair
    always_comb begin
        preamble_hit = 1'b0;
        for (int off = 0; off < SEARCH_OFFSETS; off++) begin
            if ((cur_pair[off +: PREAMBLE_SPAN] & PREAMBLE_MASK) == PREAMBLE_VALUE) begin
                preamble_hit = 1'b1;
            end
        end
    end

    always_comb begin
        state_nxt = state;
        if (!window_valid) begin
            state_nxt = ALIGN_IDLE;
        end else if ((state != ALIGN_LOCKED) && preamble_hit) begin
            state_nxt = ALIGN_LOCKED;
        end else if (state == ALIGN_IDLE) begin
            state_nxt = ALIGN_SEARCH;
        end
    end

    always_ff @(posedge clk_div or posedge usr_rst) begin
        if (usr_rst) begin
            state <= ALIGN_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // lock and pair are both registered on the same edge
    assign bus.dqs_hist   = dqs_hist_q;
    assign bus.lock_state = state;
    assign bus.locked     = (state == ALIGN_LOCKED);

endmodule

// ==== hw/rd_capture/dq_sample_buffer.sv ====
`timescale 1ns/1ps

module dq_sample_buffer
    import nand_bus_pkg::*;
(
    input  logic                  clk_div,
    input  logic                  usr_rst,
    input  dq_slice_t             i_dq_lanes,
    rd_capture_if.buffer_mp       bus
);

    dq_slice_t sample_slice;
    dq_slice_t prev_sample;
    dq_pair_t  dq_hist_q;

    // ##################################################
    // lane order to sample order
    // ##################################################

    // input: lane L sample s at bit 8*L+s
    // output: byte s holds sample s of every lane, lane 0 in bit 0
    always_comb begin
        sample_slice = '0;
        for (int s = 0; s < SERDES_RATIO; s++) begin
            for (int l = 0; l < DQ_LANES; l++) begin
                sample_slice[s*DQ_LANES + l] = i_dq_lanes[l*SERDES_RATIO + s];
            end
        end
    end

    // ##################################################
    // two-slice history
    // ##################################################

    always_ff @(posedge clk_div or posedge usr_rst) begin
        if (usr_rst) begin
            prev_sample <= '0;
            dq_hist_q   <= '0;
        end else begin
            prev_sample <= sample_slice;
            // previous slice low, current slice high
            dq_hist_q   <= {sample_slice, prev_sample};
        end
    end

    assign bus.dq_hist = dq_hist_q;

endmodule

// ==== hw/rd_capture/rd_word_extract.sv ====
`timescale 1ns/1ps

module rd_word_extract
    import nand_bus_pkg::*, rd_align_pkg::*;
(
    input  logic                  clk_div,
    input  logic                  usr_rst,
    rd_capture_if.extract_mp      bus,
    output rd_strobe_t            o_strobe,
    output rd_word_t              o_word
);

    dqs_slice_t aligned_dqs;
    dq_slice_t  aligned_dq;
    rd_word_t   word_sel;
    logic       capture_en;
    logic       dqs_toggle;
    rd_strobe_t strobe_s1;
    rd_word_t   word_s1;

    // ##################################################
    // fixed bit-slip
    // ##################################################

    // samples 6..7 of the previous slice and 0..5 of the current one
    assign aligned_dqs = bus.dqs_hist[DQS_SLIP +: SERDES_RATIO];
    assign aligned_dq  = bus.dq_hist[DQ_SLIP +: DQ_SLICE_W];

    // high byte from the current slice, low byte from the previous slice
    assign word_sel = {aligned_dq[HI_BIT +: DQ_LANES], aligned_dq[LO_BIT +: DQ_LANES]};

    // ##################################################
    // edge check
    // ##################################################

    assign capture_en = (bus.lock_state == ALIGN_LOCKED);

    // a flat byte means no dqs edge in this slot
    assign dqs_toggle = (aligned_dqs != '0) && (aligned_dqs != '1);

    // ##################################################
    // output stages
    // ##################################################

    always_ff @(posedge clk_div or posedge usr_rst) begin
        if (usr_rst) begin
            strobe_s1 <= '0;
            word_s1   <= '0;
        end else if (capture_en && dqs_toggle) begin
            strobe_s1 <= STROBE_WORD;
            word_s1   <= word_sel;
        end else begin
            strobe_s1 <= '0;
            word_s1   <= '0;
        end
    end

    always_ff @(posedge clk_div or posedge usr_rst) begin
        if (usr_rst) begin
            o_strobe <= '0;
            o_word   <= '0;
        end else begin
            o_strobe <= strobe_s1;
            o_word   <= word_s1;
        end
    end

endmodule

// ==== hw/nand_rd_capture.sv ====
`timescale 1ns/1ps

module nand_rd_capture
    import nand_bus_pkg::*;
(
    input  logic       clk_div,
    input  logic       usr_rst,

    // deserialized dqs and dq, one slice per cycle
    input  dqs_slice_t i_dqs_slice,
    input  dq_slice_t  i_dq_lanes,

    // dqs tristate enable, 1 while receiving
    input  logic       i_rd_window,

    output rd_strobe_t o_strobe,
    output rd_word_t   o_word,
    output logic       o_locked
);

    rd_capture_if cap_bus ();

    // ##################################################
    // dqs alignment and dq history
    // ##################################################

    dqs_lock_finder u_dqs_lock_finder (
        .clk_div     (clk_div),
        .usr_rst     (usr_rst),
        .i_dqs_slice (i_dqs_slice),
        .i_rd_window (i_rd_window),
        .bus         (cap_bus)
    );

    dq_sample_buffer u_dq_sample_buffer (
        .clk_div    (clk_div),
        .usr_rst    (usr_rst),
        .i_dq_lanes (i_dq_lanes),
        .bus        (cap_bus)
    );

    // ##################################################
    // word extraction
    // ##################################################

    // strobe and word follow the history pair by two cycles
    rd_word_extract u_rd_word_extract (
        .clk_div  (clk_div),
        .usr_rst  (usr_rst),
        .bus      (cap_bus),
        .o_strobe (o_strobe),
        .o_word   (o_word)
    );

    assign o_locked = cap_bus.locked;

endmodule

// ==== sim/nand_rd_capture_asserts.sv ====
`timescale 1ns/1ps

module nand_rd_capture_asserts
    import nand_bus_pkg::*, rd_align_pkg::*;
(
    input logic       clk_div,
    input logic       usr_rst,
    input rd_strobe_t i_strobe,
    input rd_word_t   i_word,
    input logic       i_locked
);

    int fail_count = 0;

    // only idle or the data strobe code
    strobe_legal: assert property (@(posedge clk_div) disable iff (usr_rst)
        (i_strobe == '0) || (i_strobe == STROBE_WORD))
    else begin
        $error("o_strobe carries an undefined code");
        fail_count++;
    end

    // idle slots carry no data
    word_idle_zero: assert property (@(posedge clk_div) disable iff (usr_rst)
        (i_strobe == '0) |-> (i_word == '0))
    else begin
        $error("o_word is not zero while o_strobe is idle");
        fail_count++;
    end

    // strobe follows the lock of the same pair, two cycles later
    strobe_needs_lock: assert property (@(posedge clk_div) disable iff (usr_rst)
        (i_strobe != '0) |-> $past(i_locked, 2))
    else begin
        $error("o_strobe raised without lock two cycles earlier");
        fail_count++;
    end

endmodule

bind nand_rd_capture nand_rd_capture_asserts u_asserts (
    .clk_div  (clk_div),
    .usr_rst  (usr_rst),
    .i_strobe (o_strobe),
    .i_word   (o_word),
    .i_locked (o_locked)
);

// ==== sim/tb_nand_rd_capture.sv ====
`timescale 1ns/1ps

module tb_nand_rd_capture
    import nand_bus_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int NUM_TESTS  = 6;
    localparam int MAX_SLICES = 100;
    localparam int TIMEOUT_NS = NUM_TESTS * MAX_SLICES * CLK_PERIOD + 20 * CLK_PERIOD;

    logic       clk_div;
    logic       usr_rst;
    dqs_slice_t i_dqs_slice;
    dq_slice_t  i_dq_lanes;
    logic       i_rd_window;
    rd_strobe_t o_strobe;
    rd_word_t   o_word;
    logic       o_locked;

    // reference model state
    logic [15:0] lfsr;
    dqs_slice_t  m_prev_dqs;
    dq_slice_t   m_prev_dq;
    logic        m_win_prev;
    logic        m_win_valid;
    logic        m_locked;
    logic [17:0] exp_q[$];
    int          strobe_seen;

    nand_rd_capture DUT (
        .clk_div     (clk_div),
        .usr_rst     (usr_rst),
        .i_dqs_slice (i_dqs_slice),
        .i_dq_lanes  (i_dq_lanes),
        .i_rd_window (i_rd_window),
        .o_strobe    (o_strobe),
        .o_word      (o_word),
        .o_locked    (o_locked)
    );

    initial begin
        clk_div = 1'b0;
        forever #(CLK_PERIOD/2) clk_div = ~clk_div;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        wait (DUT.u_asserts.fail_count != 0);
        $display("a bound assertion on the DUT outputs failed");
        $display("TEST FAIL");
        $fatal(1, "assertion failure");
    end

    // ##################################################
    // helpers
    // ##################################################

    // galois lfsr with polynomial x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic next_rand_bit();
        logic lsb;
        lsb  = lfsr[0];
        lfsr = lfsr >> 1;
        if (lsb) begin
            lfsr = lfsr ^ 16'hB400;
        end
        return lsb;
    endfunction

    function automatic dq_slice_t rand_dq();
        dq_slice_t v;
        for (int i = 0; i < 64; i++) begin
            v[i] = next_rand_bit();
        end
        return v;
    endfunction

    // sample s of every lane, lane 0 in bit 0
    function automatic logic [7:0] sample_byte(dq_slice_t lanes, int s);
        logic [7:0] b;
        for (int l = 0; l < 8; l++) begin
            b[l] = lanes[l*8 + s];
        end
        return b;
    endfunction

    // two lows, two don't-cares, three highs at start offsets 0..7
    function automatic logic has_preamble(dqs_slice_t prev, dqs_slice_t cur);
        logic [15:0] p;
        logic        hit;
        p   = {cur, prev};
        hit = 1'b0;
        for (int off = 0; off < 8; off++) begin
            if (!p[off] && !p[off+1] && p[off+4] && p[off+5] && p[off+6]) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // called at a falling edge, returns at the next falling edge
    task automatic drive_cycle(string name, dqs_slice_t dqs, dq_slice_t dq, logic win);
        logic        hit;
        logic [7:0]  aligned;
        logic [17:0] decision;
        logic [17:0] expected;
        i_dqs_slice = dqs;
        i_dq_lanes  = dq;
        i_rd_window = win;
        @(posedge clk_div);
        hit = has_preamble(m_prev_dqs, dqs);
        // lock uses the qualified window from before this edge
        if (!m_win_valid) begin
            m_locked = 1'b0;
        end else if (!m_locked && hit) begin
            m_locked = 1'b1;
        end
        m_win_valid = m_win_prev & win;
        m_win_prev  = win;
        aligned = {dqs[5:0], m_prev_dqs[7:6]};
        if (m_locked && (aligned != 8'h00) && (aligned != 8'hFF)) begin
            decision = {2'b01, sample_byte(dq, 3), sample_byte(m_prev_dq, 7)};
        end else begin
            decision = '0;
        end
        // two-deep queue gives the 2-cycle output delay
        exp_q.push_back(decision);
        expected   = exp_q.pop_front();
        m_prev_dqs = dqs;
        m_prev_dq  = dq;
        @(negedge clk_div);
        check_value({name, " strobe"}, expected[17:16], o_strobe);
        check_value({name, " word"}, expected[15:0], o_word);
        check_value({name, " locked"}, m_locked, o_locked);
        if (o_strobe != '0) begin
            strobe_seen++;
        end
    endtask

    function automatic dqs_slice_t toggle_dqs(int i);
        return (i % 2 == 0) ? 8'h55 : 8'hAA;
    endfunction

    // ##################################################
    // directed tests
    // ##################################################

    task automatic test_reset();
        repeat (3) begin
            @(negedge clk_div);
            check_value("reset strobe", 0, o_strobe);
            check_value("reset word", 0, o_word);
            check_value("reset locked", 0, o_locked);
        end
        usr_rst = 1'b0;
        repeat (3) drive_cycle("reset", 8'h00, '0, 1'b0);
    endtask

    task automatic test_closed_window();
        strobe_seen = 0;
        drive_cycle("closed_window", 8'h55, rand_dq(), 1'b0);
        drive_cycle("closed_window", 8'h00, rand_dq(), 1'b0);
        // single open slice is not a qualified window
        drive_cycle("closed_window", 8'hE0, rand_dq(), 1'b1);
        drive_cycle("closed_window", 8'h55, rand_dq(), 1'b0);
        for (int i = 0; i < 6; i++) begin
            drive_cycle("closed_window", toggle_dqs(i), rand_dq(), 1'b0);
        end
        check_value("closed_window lock", 0, o_locked);
        check_value("closed_window strobe count", 0, strobe_seen);
    endtask

    task automatic test_lock_capture();
        repeat (3) drive_cycle("lock_capture", 8'h00, rand_dq(), 1'b1);
        drive_cycle("lock_capture", 8'hE0, rand_dq(), 1'b1);
        drive_cycle("lock_capture", 8'h55, rand_dq(), 1'b1);
        check_value("lock_capture lock rise", 1, o_locked);
        strobe_seen = 0;
        for (int i = 1; i <= 16; i++) begin
            drive_cycle("lock_capture", toggle_dqs(i), rand_dq(), 1'b1);
        end
        // pairs from the lock edge onward, less the two still in flight
        check_value("lock_capture strobe count", 15, strobe_seen);
    endtask

    task automatic test_flat_dqs();
        repeat (4) drive_cycle("flat_dqs", 8'h00, rand_dq(), 1'b1);
        repeat (4) drive_cycle("flat_dqs", 8'hFF, rand_dq(), 1'b1);
        drive_cycle("flat_dqs", 8'h55, rand_dq(), 1'b1);
        drive_cycle("flat_dqs", 8'hAA, rand_dq(), 1'b1);
        check_value("flat_dqs lock held", 1, o_locked);
    endtask

    task automatic test_unlock();
        drive_cycle("unlock", 8'h55, rand_dq(), 1'b0);
        drive_cycle("unlock", 8'hAA, rand_dq(), 1'b0);
        check_value("unlock lock fall", 0, o_locked);
        drive_cycle("unlock", 8'h55, rand_dq(), 1'b0);
        drive_cycle("unlock", 8'hAA, rand_dq(), 1'b0);
        strobe_seen = 0;
        for (int i = 0; i < 8; i++) begin
            drive_cycle("unlock", toggle_dqs(i), rand_dq(), 1'b1);
        end
        check_value("unlock relock", 0, o_locked);
        check_value("unlock strobe count", 0, strobe_seen);
    endtask

    task automatic test_lane_order();
        drive_cycle("lane_order", 8'hE0, '0, 1'b1);
        drive_cycle("lane_order", 8'h55, '0, 1'b1);
        check_value("lane_order lock", 1, o_locked);
        // one set bit walks through every lane and sample
        for (int l = 0; l < 8; l++) begin
            for (int s = 0; s < 8; s++) begin
                drive_cycle("lane_order", toggle_dqs(s), 64'd1 << (l*8 + s), 1'b1);
            end
        end
        repeat (2) drive_cycle("lane_order", 8'hAA, '0, 1'b1);
    endtask

    // ##################################################
    // main sequence
    // ##################################################

    initial begin
        usr_rst     = 1'b1;
        i_dqs_slice = '0;
        i_dq_lanes  = '0;
        i_rd_window = 1'b0;
        lfsr        = 16'd26;
        m_prev_dqs  = '0;
        m_prev_dq   = '0;
        m_win_prev  = 1'b0;
        m_win_valid = 1'b0;
        m_locked    = 1'b0;
        exp_q       = {18'd0, 18'd0};
        strobe_seen = 0;

        test_reset();
        test_closed_window();
        test_lock_capture();
        test_flat_dqs();
        test_unlock();
        test_lane_order();

        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== compile.f ====
common/nand_bus_pkg.sv
common/rd_align_pkg.sv
common/rd_capture_if.sv
hw/rd_capture/dqs_lock_finder.sv
hw/rd_capture/dq_sample_buffer.sv
hw/rd_capture/rd_word_extract.sv
hw/nand_rd_capture.sv
sim/nand_rd_capture_asserts.sv
sim/tb_nand_rd_capture.sv

// ==== Bender.yml ====
package:
  name: nand_rd_capture

sources:
  # packages and interface
  - files:
      - common/nand_bus_pkg.sv
      - common/rd_align_pkg.sv
      - common/rd_capture_if.sv
  # read-capture rtl
  - files:
      - hw/rd_capture/dqs_lock_finder.sv
      - hw/rd_capture/dq_sample_buffer.sv
      - hw/rd_capture/rd_word_extract.sv
      - hw/nand_rd_capture.sv
  # testbench and bound checker
  - target: simulation
    files:
      - sim/nand_rd_capture_asserts.sv
      - sim/tb_nand_rd_capture.sv
